// File: build.f
hdl/detector_pkg.sv
hdl/dep_pipeline.sv
hdl/int_scoreboard.sv
hdl/shared_stall_unit.sv
hdl/issue_checker.sv
hdl/hazard_detector.sv
verif/tb_hazard_detector.sv
+incdir+include

// File: hdl/dep_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module dep_pipeline
  import detector_pkg::*;
(
  input  wire                                        clk_i,
  input  wire                                        reset_i,
  input  wire                                        dispatch_v_i,
  input  wire  [reg_addr_width-1:0]                  dispatch_rd_i,
  input  wire                                        dispatch_irf_w_i,
  input  wire                                        dispatch_mem_i,
  input  wire                                        dispatch_aux_i,
  input  wire                                        dispatch_mul_i,
  input  wire                                        dispatch_mem_early_i,
  input  wire                                        dispatch_mem_final_i,
  output logic [num_stages-1:0]                      stage_v_o,
  output logic [num_stages-1:0]                      stage_mem_o,
  output logic [num_stages-1:0][reg_addr_width-1:0]  stage_rd_o,
  output logic [num_stages-1:0]                      stage_unready_o
);

  logic [num_stages-1:0] v_r;
  logic [num_stages-1:0] mem_r;
  logic [num_stages-1:0][reg_addr_width-1:0] rd_r;
  // Stage 0 result that no bypass can supply yet
  logic late0_r;
  // Mul and mem-final results that stay unready in stage 1
  logic [1:0] slow_r;
  logic late_n;
  logic slow_n;

  always_comb
  begin
    late_n = dispatch_v_i & dispatch_irf_w_i
      & (dispatch_aux_i | dispatch_mul_i | dispatch_mem_early_i | dispatch_mem_final_i);
    slow_n = dispatch_v_i & dispatch_irf_w_i & (dispatch_mul_i | dispatch_mem_final_i);
  end

  // An idle cycle shifts in an empty record
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_r <= '0;
      mem_r <= '0;
      late0_r <= 1'b0;
      slow_r <= '0;
    end
    else
    begin
      v_r <= {v_r[num_stages-2:0], dispatch_v_i};
      mem_r <= {mem_r[num_stages-2:0], dispatch_v_i & dispatch_mem_i};
      late0_r <= late_n;
      slow_r <= {slow_r[0], slow_n};
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_r <= {rd_r[num_stages-2:0], dispatch_rd_i};
  end

  assign stage_v_o = v_r;
  assign stage_mem_o = mem_r;
  assign stage_rd_o = rd_r;
  // Everything in iwb can be forwarded
  assign stage_unready_o = {1'b0, slow_r[1], late0_r};

endmodule

`default_nettype wire

// File: hdl/detector_pkg.sv
`default_nettype none

package detector_pkg;

  // Integer register file
  localparam int reg_addr_width = 5;
  localparam int num_regs = 32;

  // Two issue slots, three tracked execute stages (ex1, ex2, iwb)
  localparam int num_slots = 2;
  localparam int num_stages = 3;

  // Major opcodes whose cache miss leaves a pending integer write
  localparam int opcode_width = 7;
  localparam logic [opcode_width-1:0] load_opcode = 7'b0000011;
  localparam logic [opcode_width-1:0] amo_opcode = 7'b0101111;

endpackage

`default_nettype wire

// File: hdl/hazard_detector.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_detector
  import detector_pkg::*;
(
  input  wire                                       clk_i,
  input  wire                                       reset_i,
  // Issue candidates indexed by slot
  input  wire  [num_slots-1:0][reg_addr_width-1:0]  isd_rs1_i,
  input  wire  [num_slots-1:0][reg_addr_width-1:0]  isd_rs2_i,
  input  wire  [num_slots-1:0][reg_addr_width-1:0]  isd_rd_i,
  input  wire  [num_slots-1:0]                      isd_irs1_v_i,
  input  wire  [num_slots-1:0]                      isd_irs2_v_i,
  input  wire  [num_slots-1:0]                      isd_iwb_v_i,
  input  wire  [num_slots-1:0]                      isd_fence_v_i,
  input  wire  [num_slots-1:0]                      isd_mem_v_i,
  input  wire  [num_slots-1:0]                      isd_csr_v_i,
  input  wire  [num_slots-1:0]                      isd_long_v_i,
  // Instruction dispatched this cycle
  input  wire                                       dispatch_v_i,
  input  wire  [reg_addr_width-1:0]                 dispatch_rd_i,
  input  wire                                       dispatch_irf_w_i,
  input  wire                                       dispatch_mem_i,
  input  wire                                       dispatch_late_i,
  input  wire                                       dispatch_aux_i,
  input  wire                                       dispatch_mul_i,
  input  wire                                       dispatch_mem_early_i,
  input  wire                                       dispatch_mem_final_i,
  // Commit miss and late writeback
  input  wire                                       commit_miss_i,
  input  wire  [reg_addr_width-1:0]                 commit_rd_i,
  input  wire  [opcode_width-1:0]                   commit_opcode_i,
  input  wire                                       iwb_w_v_i,
  input  wire                                       iwb_late_i,
  input  wire  [reg_addr_width-1:0]                 iwb_rd_i,
  input  wire                                       cmd_full_i,
  input  wire                                       credits_full_i,
  input  wire                                       credits_empty_i,
  input  wire                                       idiv_ready_i,
  input  wire                                       fdiv_ready_i,
  input  wire                                       mem_ready_i,
  input  wire                                       ptw_busy_i,
  input  wire                                       irq_pending_i,
  output logic [num_slots-1:0]                      dispatch_v_o,
  output logic                                      interrupt_v_o
);

  logic [num_stages-1:0] stage_v;
  logic [num_stages-1:0] stage_mem;
  logic [num_stages-1:0][reg_addr_width-1:0] stage_rd;
  logic [num_stages-1:0] stage_unready;
  logic [num_slots-1:0] sb_rs1_hit;
  logic [num_slots-1:0] sb_rs2_hit;
  logic [num_slots-1:0] sb_rd_hit;
  logic pipe_busy;
  logic fence_block;
  logic common_stall;

  dep_pipeline dep_pipe (
    .clk_i(clk_i), .reset_i(reset_i),
    .dispatch_v_i(dispatch_v_i), .dispatch_rd_i(dispatch_rd_i),
    .dispatch_irf_w_i(dispatch_irf_w_i), .dispatch_mem_i(dispatch_mem_i),
    .dispatch_aux_i(dispatch_aux_i), .dispatch_mul_i(dispatch_mul_i),
    .dispatch_mem_early_i(dispatch_mem_early_i), .dispatch_mem_final_i(dispatch_mem_final_i),
    .stage_v_o(stage_v), .stage_mem_o(stage_mem),
    .stage_rd_o(stage_rd), .stage_unready_o(stage_unready)
  );

  int_scoreboard int_sb (
    .clk_i(clk_i), .reset_i(reset_i),
    .dispatch_v_i(dispatch_v_i), .dispatch_late_i(dispatch_late_i),
    .dispatch_rd_i(dispatch_rd_i),
    .commit_miss_i(commit_miss_i), .commit_opcode_i(commit_opcode_i),
    .commit_rd_i(commit_rd_i),
    .iwb_w_v_i(iwb_w_v_i), .iwb_late_i(iwb_late_i), .iwb_rd_i(iwb_rd_i),
    .isd_rs1_i(isd_rs1_i), .isd_rs2_i(isd_rs2_i), .isd_rd_i(isd_rd_i),
    .sb_rs1_hit_o(sb_rs1_hit), .sb_rs2_hit_o(sb_rs2_hit), .sb_rd_hit_o(sb_rd_hit)
  );

  shared_stall_unit stall_unit (
    .credits_empty_i(credits_empty_i), .mem_ready_i(mem_ready_i),
    .cmd_full_i(cmd_full_i), .ptw_busy_i(ptw_busy_i), .irq_pending_i(irq_pending_i),
    .stage_v_i(stage_v), .stage_mem_i(stage_mem),
    .pipe_busy_o(pipe_busy), .fence_block_o(fence_block),
    .common_stall_o(common_stall), .interrupt_v_o(interrupt_v_o)
  );

  issue_checker slot0_checker (
    .isd_rs1_i(isd_rs1_i[0]), .isd_rs2_i(isd_rs2_i[0]), .isd_rd_i(isd_rd_i[0]),
    .isd_irs1_v_i(isd_irs1_v_i[0]), .isd_irs2_v_i(isd_irs2_v_i[0]),
    .isd_iwb_v_i(isd_iwb_v_i[0]), .isd_fence_v_i(isd_fence_v_i[0]),
    .isd_mem_v_i(isd_mem_v_i[0]), .isd_csr_v_i(isd_csr_v_i[0]),
    .isd_long_v_i(isd_long_v_i[0]),
    .stage_rd_i(stage_rd), .stage_unready_i(stage_unready),
    .sb_rs1_hit_i(sb_rs1_hit[0]), .sb_rs2_hit_i(sb_rs2_hit[0]), .sb_rd_hit_i(sb_rd_hit[0]),
    .pipe_busy_i(pipe_busy), .fence_block_i(fence_block), .common_stall_i(common_stall),
    .credits_full_i(credits_full_i), .mem_ready_i(mem_ready_i),
    .idiv_ready_i(idiv_ready_i), .fdiv_ready_i(fdiv_ready_i),
    .dispatch_v_o(dispatch_v_o[0])
  );

  issue_checker slot1_checker (
    .isd_rs1_i(isd_rs1_i[1]), .isd_rs2_i(isd_rs2_i[1]), .isd_rd_i(isd_rd_i[1]),
    .isd_irs1_v_i(isd_irs1_v_i[1]), .isd_irs2_v_i(isd_irs2_v_i[1]),
    .isd_iwb_v_i(isd_iwb_v_i[1]), .isd_fence_v_i(isd_fence_v_i[1]),
    .isd_mem_v_i(isd_mem_v_i[1]), .isd_csr_v_i(isd_csr_v_i[1]),
    .isd_long_v_i(isd_long_v_i[1]),
    .stage_rd_i(stage_rd), .stage_unready_i(stage_unready),
    .sb_rs1_hit_i(sb_rs1_hit[1]), .sb_rs2_hit_i(sb_rs2_hit[1]), .sb_rd_hit_i(sb_rd_hit[1]),
    .pipe_busy_i(pipe_busy), .fence_block_i(fence_block), .common_stall_i(common_stall),
    .credits_full_i(credits_full_i), .mem_ready_i(mem_ready_i),
    .idiv_ready_i(idiv_ready_i), .fdiv_ready_i(fdiv_ready_i),
    .dispatch_v_o(dispatch_v_o[1])
  );

endmodule

`default_nettype wire

// File: hdl/int_scoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module int_scoreboard
  import detector_pkg::*;
(
  input  wire                                       clk_i,
  input  wire                                       reset_i,
  input  wire                                       dispatch_v_i,
  input  wire                                       dispatch_late_i,
  input  wire  [reg_addr_width-1:0]                 dispatch_rd_i,
  input  wire                                       commit_miss_i,
  input  wire  [opcode_width-1:0]                   commit_opcode_i,
  input  wire  [reg_addr_width-1:0]                 commit_rd_i,
  input  wire                                       iwb_w_v_i,
  input  wire                                       iwb_late_i,
  input  wire  [reg_addr_width-1:0]                 iwb_rd_i,
  input  wire  [num_slots-1:0][reg_addr_width-1:0]  isd_rs1_i,
  input  wire  [num_slots-1:0][reg_addr_width-1:0]  isd_rs2_i,
  input  wire  [num_slots-1:0][reg_addr_width-1:0]  isd_rd_i,
  output logic [num_slots-1:0]                      sb_rs1_hit_o,
  output logic [num_slots-1:0]                      sb_rs2_hit_o,
  output logic [num_slots-1:0]                      sb_rd_hit_o
);

  logic [num_regs-1:0] pending_r;
  logic [num_regs-1:0] pending_n;
  logic commit_score;
  logic score_v;
  logic clear_v;
  logic [reg_addr_width-1:0] score_rd;

  always_comb
  begin
    commit_score = commit_miss_i
      & ((commit_opcode_i == load_opcode) | (commit_opcode_i == amo_opcode));
    score_v = commit_score | (dispatch_v_i & dispatch_late_i);
    // A missed load or AMO owns the single set port
    score_rd = commit_score ? commit_rd_i : dispatch_rd_i;
    clear_v = iwb_w_v_i & iwb_late_i;
    pending_n = pending_r;
    // Clear before set, so a set to the same register wins
    if (clear_v)
      pending_n[iwb_rd_i] = 1'b0;
    if (score_v)
      pending_n[score_rd] = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pending_r <= '0;
    else
      pending_r <= pending_n;
  end

  always_comb
  begin
    for (int s = 0; s < num_slots; s++)
    begin
      sb_rs1_hit_o[s] = pending_r[isd_rs1_i[s]];
      sb_rs2_hit_o[s] = pending_r[isd_rs2_i[s]];
      sb_rd_hit_o[s] = pending_r[isd_rd_i[s]];
    end
  end

endmodule

`default_nettype wire

// File: hdl/issue_checker.sv
`timescale 1ns/100ps
`default_nettype none

module issue_checker
  import detector_pkg::*;
(
  input  wire  [reg_addr_width-1:0]                  isd_rs1_i,
  input  wire  [reg_addr_width-1:0]                  isd_rs2_i,
  input  wire  [reg_addr_width-1:0]                  isd_rd_i,
  input  wire                                        isd_irs1_v_i,
  input  wire                                        isd_irs2_v_i,
  input  wire                                        isd_iwb_v_i,
  input  wire                                        isd_fence_v_i,
  input  wire                                        isd_mem_v_i,
  input  wire                                        isd_csr_v_i,
  input  wire                                        isd_long_v_i,
  input  wire  [num_stages-1:0][reg_addr_width-1:0]  stage_rd_i,
  input  wire  [num_stages-1:0]                      stage_unready_i,
  input  wire                                        sb_rs1_hit_i,
  input  wire                                        sb_rs2_hit_i,
  input  wire                                        sb_rd_hit_i,
  input  wire                                        pipe_busy_i,
  input  wire                                        fence_block_i,
  input  wire                                        common_stall_i,
  input  wire                                        credits_full_i,
  input  wire                                        mem_ready_i,
  input  wire                                        idiv_ready_i,
  input  wire                                        fdiv_ready_i,
  output logic                                       dispatch_v_o
);

  logic [num_stages-1:0] rs1_fwd_haz;
  logic [num_stages-1:0] rs2_fwd_haz;
  logic rs1_live;
  logic rs2_live;
  logic rd_live;
  logic data_haz;
  logic control_haz;
  logic struct_haz;

  always_comb
  begin
    // x0 never carries a dependency
    rs1_live = isd_irs1_v_i & (isd_rs1_i != '0);
    rs2_live = isd_irs2_v_i & (isd_rs2_i != '0);
    rd_live = isd_iwb_v_i & (isd_rd_i != '0);

    // Match against results that cannot be bypassed yet
    for (int i = 0; i < num_stages; i++)
    begin
      rs1_fwd_haz[i] = stage_unready_i[i] & (isd_rs1_i == stage_rd_i[i]);
      rs2_fwd_haz[i] = stage_unready_i[i] & (isd_rs2_i == stage_rd_i[i]);
    end

    // RAW on forwarding or scoreboard, WAW on scoreboard
    data_haz = (rs1_live & ((|rs1_fwd_haz) | sb_rs1_hit_i))
      | (rs2_live & ((|rs2_fwd_haz) | sb_rs2_hit_i))
      | (rd_live & sb_rd_hit_i);

    control_haz = (isd_fence_v_i & fence_block_i)
      | (isd_mem_v_i & credits_full_i)
      | ((isd_csr_v_i | isd_long_v_i) & pipe_busy_i);

    // Long ops need both dividers free
    struct_haz = common_stall_i
      | (isd_mem_v_i & ~mem_ready_i)
      | (isd_long_v_i & ~(idiv_ready_i & fdiv_ready_i));
  end

  assign dispatch_v_o = ~(data_haz | control_haz | struct_haz);

endmodule

`default_nettype wire

// File: hdl/shared_stall_unit.sv
`timescale 1ns/100ps
`default_nettype none

module shared_stall_unit
  import detector_pkg::*;
(
  input  wire                   credits_empty_i,
  input  wire                   mem_ready_i,
  input  wire                   cmd_full_i,
  input  wire                   ptw_busy_i,
  input  wire                   irq_pending_i,
  input  wire  [num_stages-1:0] stage_v_i,
  input  wire  [num_stages-1:0] stage_mem_i,
  output logic                  pipe_busy_o,
  output logic                  fence_block_o,
  output logic                  common_stall_o,
  output logic                  interrupt_v_o
);

  // CSR and long ops wait for an empty pipe
  assign pipe_busy_o = |stage_v_i;

  // A fence waits until every memory op has drained
  assign fence_block_o = ~credits_empty_i | (|stage_mem_i) | ~mem_ready_i;

  assign common_stall_o = ptw_busy_i | cmd_full_i;

  // Interrupts are held off during a page-table walk
  assign interrupt_v_o = irq_pending_i & ~ptw_busy_i;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run the testbench and scan its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f build.f --top-module tb_hazard_detector \
  -o tb_hazard_detector > sim.log 2>&1 &&
  ./obj_dir/tb_hazard_detector >> sim.log 2>&1 ||
  { echo "Build or simulation error, see sim.log"; exit 1; }
grep -q "Something failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"

// File: include/detector_model.svh
`ifndef DETECTOR_MODEL_SVH
`define DETECTOR_MODEL_SVH

// Expected stage queue and late-write mask
logic [num_stages-1:0] m_v;
logic [num_stages-1:0] m_mem;
logic [num_stages-1:0] m_unready;
logic [num_stages-1:0][reg_addr_width-1:0] m_rd;
// Stage 0 result that stays unready through stage 1
logic m_slow0;
logic [num_regs-1:0] m_pending;

task automatic model_reset();
  m_v = '0;
  m_mem = '0;
  m_unready = '0;
  m_rd = '0;
  m_slow0 = 1'b0;
  m_pending = '0;
endtask

// One rising edge worth of pipeline shift and scoreboard update
task automatic model_step(
  input logic dv, input logic [reg_addr_width-1:0] drd, input logic irf_w,
  input logic mem, input logic late, input logic aux, input logic mul,
  input logic emem, input logic fmem,
  input logic cmiss, input logic [opcode_width-1:0] copc, input logic [reg_addr_width-1:0] crd,
  input logic iw_v, input logic iw_late, input logic [reg_addr_width-1:0] iw_rd);
  logic commit_set;
  commit_set = cmiss & ((copc == load_opcode) | (copc == amo_opcode));
  m_unready = {1'b0, m_slow0, dv & irf_w & (aux | mul | emem | fmem)};
  m_slow0 = dv & irf_w & (mul | fmem);
  m_v = {m_v[num_stages-2:0], dv};
  m_mem = {m_mem[num_stages-2:0], dv & mem};
  m_rd = {m_rd[num_stages-2:0], drd};
  if (iw_v && iw_late)
    m_pending[iw_rd] = 1'b0;
  if (commit_set)
    m_pending[crd] = 1'b1;
  else if (dv && late)
    m_pending[drd] = 1'b1;
endtask

// Expected dispatch_v for one slot
function automatic logic model_dispatch(
  input logic [reg_addr_width-1:0] rs1, input logic [reg_addr_width-1:0] rs2,
  input logic [reg_addr_width-1:0] rd, input logic irs1_v, input logic irs2_v,
  input logic iwb_v, input logic fence, input logic mem, input logic csr, input logic long_op,
  input logic credits_full, input logic credits_empty, input logic mem_ready,
  input logic idiv_ready, input logic fdiv_ready, input logic cmd_full, input logic ptw_busy);
  logic haz;
  haz = 1'b0;
  for (int i = 0; i < num_stages; i++)
  begin
    haz |= m_unready[i] & irs1_v & (rs1 != '0) & (rs1 == m_rd[i]);
    haz |= m_unready[i] & irs2_v & (rs2 != '0) & (rs2 == m_rd[i]);
  end
  haz |= irs1_v & (rs1 != '0) & m_pending[rs1];
  haz |= irs2_v & (rs2 != '0) & m_pending[rs2];
  haz |= iwb_v & (rd != '0) & m_pending[rd];
  haz |= fence & (~credits_empty | (|m_mem) | ~mem_ready);
  haz |= (mem & (credits_full | ~mem_ready)) | ((csr | long_op) & (|m_v));
  haz |= ptw_busy | cmd_full | (long_op & ~(idiv_ready & fdiv_ready));
  return ~haz;
endfunction

function automatic logic model_interrupt(input logic irq_pending, input logic ptw_busy);
  return irq_pending & ~ptw_busy;
endfunction

`endif

// File: verif/tb_hazard_detector.sv
`timescale 1ns/100ps
`default_nettype none

module tb_hazard_detector
  import detector_pkg::*;
();

  localparam int reset_cycles = 8;
  localparam int idle_len = 24;
  localparam int fwd_len = 300;
  localparam int sb_len = 300;
  localparam int ctrl_len = 300;
  localparam int mixed_len = 600;
  localparam int total_len = idle_len + fwd_len + sb_len + ctrl_len + mixed_len;
  localparam int timeout_cycles = (total_len * 3) / 2 + reset_cycles;

  logic clk_i;
  logic reset_i;
  logic [num_slots-1:0][reg_addr_width-1:0] isd_rs1_i, isd_rs2_i, isd_rd_i;
  logic [num_slots-1:0] isd_irs1_v_i, isd_irs2_v_i, isd_iwb_v_i;
  logic [num_slots-1:0] isd_fence_v_i, isd_mem_v_i, isd_csr_v_i, isd_long_v_i;
  logic dispatch_v_i, dispatch_irf_w_i, dispatch_mem_i, dispatch_late_i;
  logic dispatch_aux_i, dispatch_mul_i, dispatch_mem_early_i, dispatch_mem_final_i;
  logic [reg_addr_width-1:0] dispatch_rd_i, commit_rd_i, iwb_rd_i;
  logic [opcode_width-1:0] commit_opcode_i;
  logic commit_miss_i, iwb_w_v_i, iwb_late_i;
  logic cmd_full_i, credits_full_i, credits_empty_i, idiv_ready_i, fdiv_ready_i;
  logic mem_ready_i, ptw_busy_i, irq_pending_i;
  logic [num_slots-1:0] dispatch_v_o;
  logic interrupt_v_o;

  integer seed;
  int checks;
  int errors;
  int cycles;

  hazard_detector DUT (.*);

`include "detector_model.svh"

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // True with a probability of pct percent
  function automatic logic rand_chance(input int pct);
    logic [31:0] r;
    r = $random(seed);
    return (r % 32'd100) < pct;
  endfunction

  function automatic logic [reg_addr_width-1:0] rand_reg(input logic [reg_addr_width-1:0] mask);
    logic [31:0] r;
    r = $random(seed);
    return r[reg_addr_width-1:0] & mask;
  endfunction

  function automatic logic [num_slots-1:0] expected_dispatch();
    logic [num_slots-1:0] exp_v;
    for (int s = 0; s < num_slots; s++)
      exp_v[s] = model_dispatch(isd_rs1_i[s], isd_rs2_i[s], isd_rd_i[s], isd_irs1_v_i[s],
        isd_irs2_v_i[s], isd_iwb_v_i[s], isd_fence_v_i[s], isd_mem_v_i[s], isd_csr_v_i[s],
        isd_long_v_i[s], credits_full_i, credits_empty_i, mem_ready_i, idiv_ready_i,
        fdiv_ready_i, cmd_full_i, ptw_busy_i);
    return exp_v;
  endfunction

  task automatic check_dispatch(input logic [num_slots-1:0] actual,
                                input logic [num_slots-1:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Error: dispatch_v_o expected %h got %h at cycle %0d", expected, actual, cycles);
    end
  endtask

  task automatic check_interrupt(input logic actual, input logic expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("Error: interrupt_v_o expected %h got %h at cycle %0d", expected, actual, cycles);
    end
  endtask

  // Quiet cycle with no class flags and every ready high
  task automatic drive_idle();
    for (int s = 0; s < num_slots; s++)
    begin
      isd_rs1_i[s] = rand_reg(5'h1f);
      isd_rs2_i[s] = rand_reg(5'h1f);
      isd_rd_i[s] = rand_reg(5'h1f);
      isd_irs1_v_i[s] = rand_bit();
      isd_irs2_v_i[s] = rand_bit();
      isd_iwb_v_i[s] = rand_bit();
    end
    {isd_fence_v_i, isd_mem_v_i, isd_csr_v_i, isd_long_v_i} = '0;
    {dispatch_v_i, dispatch_rd_i, dispatch_irf_w_i, dispatch_mem_i, dispatch_late_i} = '0;
    {dispatch_aux_i, dispatch_mul_i, dispatch_mem_early_i, dispatch_mem_final_i} = '0;
    {commit_miss_i, commit_rd_i, commit_opcode_i, iwb_w_v_i, iwb_late_i, iwb_rd_i} = '0;
    {cmd_full_i, credits_full_i, ptw_busy_i} = '0;
    {credits_empty_i, idiv_ready_i, fdiv_ready_i, mem_ready_i} = '1;
    irq_pending_i = rand_bit();
  endtask

  // Narrow register range so dispatches and sources collide often
  task automatic drive_pipe();
    dispatch_v_i = rand_chance(60);
    dispatch_rd_i = rand_reg(5'h07);
    dispatch_irf_w_i = rand_chance(80);
    dispatch_mem_i = rand_chance(30);
    dispatch_aux_i = rand_chance(25);
    dispatch_mul_i = rand_chance(25);
    dispatch_mem_early_i = rand_chance(25);
    dispatch_mem_final_i = rand_chance(25);
    for (int s = 0; s < num_slots; s++)
    begin
      isd_rs1_i[s] = rand_reg(5'h07);
      isd_rs2_i[s] = rand_reg(5'h07);
      isd_rd_i[s] = rand_reg(5'h07);
    end
  endtask

  task automatic drive_late();
    dispatch_late_i = rand_chance(40);
    commit_miss_i = rand_chance(30);
    commit_rd_i = rand_reg(5'h07);
    commit_opcode_i = rand_bit() ? load_opcode : (rand_bit() ? amo_opcode : 7'h13);
    iwb_w_v_i = rand_chance(60);
    iwb_late_i = rand_chance(80);
    // Often clear the register that a dispatch sets in the same cycle
    iwb_rd_i = rand_chance(25) ? dispatch_rd_i : rand_reg(5'h07);
  endtask

  task automatic drive_control();
    for (int s = 0; s < num_slots; s++)
    begin
      isd_fence_v_i[s] = rand_chance(25);
      isd_mem_v_i[s] = rand_chance(25);
      isd_csr_v_i[s] = rand_chance(25);
      isd_long_v_i[s] = rand_chance(25);
    end
    credits_full_i = rand_chance(30);
    credits_empty_i = rand_chance(70);
    mem_ready_i = rand_chance(80);
  endtask

  task automatic drive_struct();
    cmd_full_i = rand_chance(15);
    idiv_ready_i = rand_chance(80);
    fdiv_ready_i = rand_chance(80);
  endtask

  // Inputs are stable here, so compare just before the edge, then advance the model
  task automatic step_and_check();
    #6;
    check_dispatch(dispatch_v_o, expected_dispatch());
    check_interrupt(interrupt_v_o, model_interrupt(irq_pending_i, ptw_busy_i));
    @(posedge clk_i);
    model_step(dispatch_v_i, dispatch_rd_i, dispatch_irf_w_i, dispatch_mem_i, dispatch_late_i,
      dispatch_aux_i, dispatch_mul_i, dispatch_mem_early_i, dispatch_mem_final_i,
      commit_miss_i, commit_opcode_i, commit_rd_i, iwb_w_v_i, iwb_late_i, iwb_rd_i);
    #1;
  endtask

  // Knob bits select pipe and sources, late writes, control, structural and ptw busy
  task automatic run_test(input string name, input logic [4:0] knobs, input int len);
    int errors_before;
    errors_before = errors;
    for (int c = 0; c < len; c++)
    begin
      drive_idle();
      if (knobs[0])
        drive_pipe();
      if (knobs[1])
        drive_late();
      if (knobs[2])
        drive_control();
      if (knobs[3])
        drive_struct();
      if (knobs[4])
        ptw_busy_i = rand_chance(20);
      step_and_check();
    end
    $display("Test %-12s %0d cycles, %0d errors", name, len, errors - errors_before);
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial
  begin
    cycles = 0;
    while (cycles < timeout_cycles)
    begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", timeout_cycles);
    $display("Something failed");
    $finish;
  end

  initial
  begin
    seed = 32'h875d;
    checks = 0;
    errors = 0;
    model_reset();
    drive_idle();
    reset_i = 1'b1;
    repeat (reset_cycles) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    model_reset();
    run_test("idle", 5'b10000, idle_len);
    run_test("forwarding", 5'b00001, fwd_len);
    run_test("scoreboard", 5'b00011, sb_len);
    run_test("control", 5'b00101, ctrl_len);
    run_test("mixed", 5'b11111, mixed_len);
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
